// File: source/accel_pkg.sv
package accel_pkg;

	// clk cycles per SCK half period, any value from 2 up works
	localparam logic [11:0] spi_half_clk = 12'd4;
	localparam logic [4:0] frame_bits = 5'd16;

	// host register map
	localparam logic [3:0] reg_ctrl = 4'd0;
	localparam logic [3:0] reg_cfg_addr = 4'd1;
	localparam logic [3:0] reg_cfg_data = 4'd2;
	localparam logic [3:0] reg_status = 4'd3;
	localparam logic [3:0] reg_x_l = 4'd4;
	localparam logic [3:0] reg_x_h = 4'd5;
	localparam logic [3:0] reg_y_l = 4'd6;
	localparam logic [3:0] reg_y_h = 4'd7;
	localparam logic [3:0] reg_z_l = 4'd8;
	localparam logic [3:0] reg_z_h = 4'd9;

	localparam int unsigned ctrl_start_bit = 0;
	localparam int unsigned ctrl_cfg_en_bit = 1;
	localparam int unsigned status_busy_bit = 0;
	localparam int unsigned status_valid_bit = 1;

	// sensor address of X high, the other five data bytes follow it
	localparam logic [6:0] accel_data_base = 7'h3B;

	localparam logic [1:0] seq_idle = 2'd0;
	localparam logic [1:0] seq_issue = 2'd1;
	localparam logic [1:0] seq_wait = 2'd2;
	localparam logic [1:0] seq_finish = 2'd3;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} axis_bytes_t;

	typedef union packed {
		axis_bytes_t b;
		logic signed [15:0] s;
	} axis_sample_u;

endpackage

// File: source/spi_accel_master.sv
`timescale 1ns/1ps

module spi_accel_master (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic frame_rd,
	input logic [6:0] frame_addr,
	input logic [7:0] frame_wr_data,
	output logic frame_busy,
	output logic frame_done,
	output logic [7:0] frame_rd_data,
	output logic spi_ss,
	output logic spi_sck,
	output logic spi_mosi,
	input logic spi_miso
);

	logic [11:0] half_cnt;
	logic [4:0] bit_cnt;
	logic [15:0] tx_shift;
	logic rd_q;
	logic half_end;
	logic load;
	logic rise_edge;
	logic fall_edge;
	logic frame_end;

	assign half_end = (half_cnt == accel_pkg::spi_half_clk - 12'd1);
	assign load = frame_start && !frame_busy;

	// SCK toggles at the end of each half period, the frame closes after
	// the high half that follows the last rising edge
	assign rise_edge = frame_busy && half_end && !spi_sck;
	assign frame_end = frame_busy && half_end && spi_sck && (bit_cnt == accel_pkg::frame_bits);
	assign fall_edge = frame_busy && half_end && spi_sck && (bit_cnt != accel_pkg::frame_bits);

	always_ff @(posedge clk) begin
		if (rst) begin
			half_cnt <= '0;
			bit_cnt <= '0;
			frame_busy <= 1'b0;
			frame_done <= 1'b0;
			spi_ss <= 1'b1;
			spi_sck <= 1'b1;
			spi_mosi <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (load) begin
				frame_busy <= 1'b1;
				spi_ss <= 1'b0;
				half_cnt <= '0;
				bit_cnt <= '0;
			end else if (frame_busy) begin
				if (half_end) begin
					half_cnt <= '0;
				end else begin
					half_cnt <= half_cnt + 12'd1;
				end
			end
			if (rise_edge) begin
				spi_sck <= 1'b1;
				bit_cnt <= bit_cnt + 5'd1;
			end
			if (fall_edge) begin
				spi_sck <= 1'b0;
				spi_mosi <= tx_shift[15];
			end
			if (frame_end) begin
				spi_ss <= 1'b1;
				spi_mosi <= 1'b0;
				frame_busy <= 1'b0;
				frame_done <= 1'b1;
			end
		end
	end

	// R/W flag, address and data go out MSB first
	always_ff @(posedge clk) begin
		if (load) begin
			tx_shift <= {frame_rd, frame_addr, frame_wr_data};
			rd_q <= frame_rd;
		end else if (fall_edge) begin
			tx_shift <= {tx_shift[14:0], 1'b0};
		end
		// data bits arrive on rising edges 8 through 15
		if (rise_edge && rd_q && bit_cnt[3]) begin
			frame_rd_data <= {frame_rd_data[6:0], spi_miso};
		end
	end

	// SCK only runs inside a frame
	assert property (@(posedge clk) disable iff (rst) spi_ss |-> spi_sck);

	// the sequencer waits for an idle engine before starting a frame
	assert property (@(posedge clk) disable iff (rst) frame_start |-> !frame_busy);

endmodule

// File: source/accel_sequencer.sv
`timescale 1ns/1ps

module accel_sequencer (
	input logic clk,
	input logic rst,
	input logic meas_start,
	input logic cfg_en,
	input logic [6:0] cfg_addr,
	input logic [7:0] cfg_data,
	output logic seq_busy,
	output logic meas_done,
	output accel_pkg::axis_sample_u sample_x,
	output accel_pkg::axis_sample_u sample_y,
	output accel_pkg::axis_sample_u sample_z,
	output logic frame_start,
	output logic frame_rd,
	output logic [6:0] frame_addr,
	output logic [7:0] frame_wr_data,
	input logic frame_busy,
	input logic frame_done,
	input logic [7:0] frame_rd_data
);

	logic [1:0] state;
	logic [2:0] rd_idx;
	logic cfg_phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= accel_pkg::seq_idle;
			rd_idx <= '0;
			cfg_phase <= 1'b0;
			seq_busy <= 1'b0;
			meas_done <= 1'b0;
			frame_start <= 1'b0;
			frame_rd <= 1'b0;
			frame_addr <= '0;
			frame_wr_data <= '0;
			sample_x.s <= 16'sd0;
			sample_y.s <= 16'sd0;
			sample_z.s <= 16'sd0;
		end else begin
			frame_start <= 1'b0;
			meas_done <= 1'b0;
			case (state)
				accel_pkg::seq_idle: begin
					if (meas_start) begin
						seq_busy <= 1'b1;
						cfg_phase <= cfg_en;
						rd_idx <= '0;
						state <= accel_pkg::seq_issue;
					end
				end
				accel_pkg::seq_issue: begin
					if (!frame_busy) begin
						frame_start <= 1'b1;
						if (cfg_phase) begin
							frame_rd <= 1'b0;
							frame_addr <= cfg_addr;
							frame_wr_data <= cfg_data;
						end else begin
							frame_rd <= 1'b1;
							frame_addr <= accel_pkg::accel_data_base + {4'b0, rd_idx};
							frame_wr_data <= '0;
						end
						state <= accel_pkg::seq_wait;
					end
				end
				accel_pkg::seq_wait: begin
					if (frame_done && cfg_phase) begin
						cfg_phase <= 1'b0;
						state <= accel_pkg::seq_issue;
					end else if (frame_done) begin
						// even index is the high byte of an axis
						case (rd_idx[2:1])
							2'd0: begin
								if (rd_idx[0]) sample_x.b.lo <= frame_rd_data;
								else sample_x.b.hi <= frame_rd_data;
							end
							2'd1: begin
								if (rd_idx[0]) sample_y.b.lo <= frame_rd_data;
								else sample_y.b.hi <= frame_rd_data;
							end
							default: begin
								if (rd_idx[0]) sample_z.b.lo <= frame_rd_data;
								else sample_z.b.hi <= frame_rd_data;
							end
						endcase
						if (rd_idx == 3'd5) begin
							meas_done <= 1'b1;
							state <= accel_pkg::seq_finish;
						end else begin
							rd_idx <= rd_idx + 3'd1;
							state <= accel_pkg::seq_issue;
						end
					end
				end
				default: begin
					seq_busy <= 1'b0;
					state <= accel_pkg::seq_idle;
				end
			endcase
		end
	end

	// samples are handed over while the measurement still counts as running
	assert property (@(posedge clk) disable iff (rst) meas_done |-> seq_busy);

endmodule

// File: source/accel_regs.sv
`timescale 1ns/1ps

module accel_regs (
	input logic clk,
	input logic rst,
	input logic host_wr,
	input logic [3:0] host_addr,
	input logic [7:0] host_wr_data,
	output logic [7:0] host_rd_data,
	output logic meas_start,
	output logic cfg_en,
	output logic [6:0] cfg_addr,
	output logic [7:0] cfg_data,
	input logic seq_busy,
	input logic meas_done,
	input accel_pkg::axis_sample_u sample_x,
	input accel_pkg::axis_sample_u sample_y,
	input accel_pkg::axis_sample_u sample_z
);

	logic ctrl_wr;
	logic cfg_en_q;
	logic valid_q;
	logic [7:0] ctrl_word;
	logic [7:0] status_word;
	accel_pkg::axis_sample_u x_q;
	accel_pkg::axis_sample_u y_q;
	accel_pkg::axis_sample_u z_q;

	assign ctrl_wr = host_wr && (host_addr == accel_pkg::reg_ctrl);
	assign meas_start = ctrl_wr && host_wr_data[accel_pkg::ctrl_start_bit] && !seq_busy;

	// a CTRL write that starts a run also picks its config mode
	assign cfg_en = ctrl_wr ? host_wr_data[accel_pkg::ctrl_cfg_en_bit] : cfg_en_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_en_q <= 1'b0;
			cfg_addr <= '0;
			cfg_data <= '0;
			valid_q <= 1'b0;
			x_q.s <= 16'sd0;
			y_q.s <= 16'sd0;
			z_q.s <= 16'sd0;
		end else begin
			if (ctrl_wr) cfg_en_q <= host_wr_data[accel_pkg::ctrl_cfg_en_bit];
			if (host_wr && host_addr == accel_pkg::reg_cfg_addr) cfg_addr <= host_wr_data[6:0];
			if (host_wr && host_addr == accel_pkg::reg_cfg_data) cfg_data <= host_wr_data;
			if (meas_done) begin
				valid_q <= 1'b1;
				x_q <= sample_x;
				y_q <= sample_y;
				z_q <= sample_z;
			end else if (meas_start) begin
				valid_q <= 1'b0;
			end
		end
	end

	// start is a pulse and always reads back as zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[accel_pkg::ctrl_cfg_en_bit] = cfg_en_q;
		status_word = '0;
		status_word[accel_pkg::status_busy_bit] = seq_busy;
		status_word[accel_pkg::status_valid_bit] = valid_q;
	end

	always_comb begin
		case (host_addr)
			accel_pkg::reg_ctrl: host_rd_data = ctrl_word;
			accel_pkg::reg_cfg_addr: host_rd_data = {1'b0, cfg_addr};
			accel_pkg::reg_cfg_data: host_rd_data = cfg_data;
			accel_pkg::reg_status: host_rd_data = status_word;
			accel_pkg::reg_x_l: host_rd_data = x_q.b.lo;
			accel_pkg::reg_x_h: host_rd_data = x_q.b.hi;
			accel_pkg::reg_y_l: host_rd_data = y_q.b.lo;
			accel_pkg::reg_y_h: host_rd_data = y_q.b.hi;
			accel_pkg::reg_z_l: host_rd_data = z_q.b.lo;
			accel_pkg::reg_z_h: host_rd_data = z_q.b.hi;
			default: host_rd_data = 8'h00;
		endcase
	end

endmodule

// File: source/accel_spi_top.sv
`timescale 1ns/1ps

module accel_spi_top (
	input logic clk,
	input logic rst,
	input logic host_wr,
	input logic [3:0] host_addr,
	input logic [7:0] host_wr_data,
	output logic [7:0] host_rd_data,
	output logic spi_ss,
	output logic spi_sck,
	output logic spi_mosi,
	input logic spi_miso
);

	logic meas_start;
	logic meas_done;
	logic cfg_en;
	logic [6:0] cfg_addr;
	logic [7:0] cfg_data;
	logic seq_busy;
	accel_pkg::axis_sample_u sample_x;
	accel_pkg::axis_sample_u sample_y;
	accel_pkg::axis_sample_u sample_z;
	logic frame_start;
	logic frame_rd;
	logic [6:0] frame_addr;
	logic [7:0] frame_wr_data;
	logic frame_busy;
	logic frame_done;
	logic [7:0] frame_rd_data;

	accel_regs u_regs (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_wr_data(host_wr_data),
		.host_rd_data(host_rd_data),
		.meas_start(meas_start),
		.cfg_en(cfg_en),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.seq_busy(seq_busy),
		.meas_done(meas_done),
		.sample_x(sample_x),
		.sample_y(sample_y),
		.sample_z(sample_z)
	);

	accel_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.meas_start(meas_start),
		.cfg_en(cfg_en),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.seq_busy(seq_busy),
		.meas_done(meas_done),
		.sample_x(sample_x),
		.sample_y(sample_y),
		.sample_z(sample_z),
		.frame_start(frame_start),
		.frame_rd(frame_rd),
		.frame_addr(frame_addr),
		.frame_wr_data(frame_wr_data),
		.frame_busy(frame_busy),
		.frame_done(frame_done),
		.frame_rd_data(frame_rd_data)
	);

	spi_accel_master u_spi (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.frame_rd(frame_rd),
		.frame_addr(frame_addr),
		.frame_wr_data(frame_wr_data),
		.frame_busy(frame_busy),
		.frame_done(frame_done),
		.frame_rd_data(frame_rd_data),
		.spi_ss(spi_ss),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso)
	);

endmodule

// File: tb/accel_slave_model.sv
`timescale 1ns/1ps

module accel_slave_model (
	input logic ss,
	input logic sck,
	input logic mosi,
	output logic miso
);

	logic [7:0] mem [0:127];
	logic [15:0] rx;
	logic [4:0] cnt;
	logic [6:0] rd_addr;

	initial begin
		rx = '0;
		cnt = '0;
		rd_addr = '0;
		miso = 1'b0;
	end

	// MOSI is sampled on rising SCK, MISO changes on falling SCK
	always @(sck) begin
		if (ss === 1'b0) begin
			if (sck) begin
				rx = {rx[14:0], mosi};
				cnt = cnt + 5'd1;
				if (cnt == 5'd8) begin
					rd_addr = rx[6:0];
				end
				if (cnt == 5'd16) begin
					if (!rx[15]) begin
						mem[rx[14:8]] = rx[7:0];
					end
					cnt = 5'd0;
				end
			end else if (cnt >= 5'd8) begin
				// falling edges after the address carry data bits 7 down to 0
				miso <= mem[rd_addr][~cnt[2:0]];
			end
		end
	end

endmodule

// File: tb/accel_checker.sv
`timescale 1ns/1ps

module accel_checker (
	input logic clk,
	input logic rst,
	input logic spi_ss,
	input logic spi_sck,
	input logic spi_mosi,
	output int error_count
);

	// each entry holds the r/w flag in bit 7 and the sensor address below it
	logic [7:0] exp_q [$];
	logic [7:0] exp_frame;
	logic [15:0] bits;
	logic in_frame;
	logic prev_ss;
	logic prev_sck;
	int rise_cnt;
	int test_errs;
	int tests_run;
	int tests_failed;

	initial begin
		error_count = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		in_frame = 1'b0;
		prev_ss = 1'b1;
		prev_sck = 1'b1;
		rise_cnt = 0;
		bits = '0;
	end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			error_count++;
			test_errs++;
		end
	endtask

	task automatic expect_frame(input logic rd, input logic [6:0] addr);
		exp_q.push_back({rd, addr});
	endtask

	task automatic finish_test(input string name);
		if (exp_q.size() != 0) begin
			$display("test %s: %0d expected SPI frames never appeared", name, exp_q.size());
			error_count++;
			test_errs++;
			exp_q.delete();
		end
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	task automatic report_totals();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
	endtask

	// sampled on clk, so SCK and SS edges show up as changes between samples
	always @(posedge clk) begin
		if (rst) begin
			in_frame = 1'b0;
			prev_ss = 1'b1;
			prev_sck = 1'b1;
		end else begin
			if (prev_ss && !spi_ss) begin
				in_frame = 1'b1;
				rise_cnt = 0;
				bits = '0;
			end else if (in_frame && !prev_sck && spi_sck) begin
				rise_cnt++;
				bits = {bits[14:0], spi_mosi};
			end
			if (in_frame && !prev_ss && spi_ss) begin
				in_frame = 1'b0;
				if (rise_cnt != 16) begin
					$display("SPI frame ending at %0d ns had %0d SCK rising edges instead of 16",
						$time, rise_cnt);
					error_count++;
					test_errs++;
				end
				if (exp_q.size() == 0) begin
					$display("SPI frame ending at %0d ns was not expected", $time);
					error_count++;
					test_errs++;
				end else begin
					exp_frame = exp_q.pop_front();
					check_value("spi_mosi r/w bit", 16'(bits[15]), 16'(exp_frame[7]));
					check_value("spi_mosi address", 16'(bits[14:8]), 16'(exp_frame[6:0]));
				end
			end
			prev_ss = spi_ss;
			prev_sck = spi_sck;
		end
	end

endmodule

// File: tb/accel_spi_tb.sv
`timescale 1ns/1ps

module accel_spi_tb;

	localparam logic [7:0] busy_mask = 8'(1 << accel_pkg::status_busy_bit);
	localparam logic [7:0] valid_mask = 8'(1 << accel_pkg::status_valid_bit);

	logic clk;
	logic rst;
	logic host_wr;
	logic [3:0] host_addr;
	logic [7:0] host_wr_data;
	logic [7:0] host_rd_data;
	logic spi_ss;
	logic spi_sck;
	logic spi_mosi;
	logic spi_miso;
	int error_count;
	logic [7:0] exp_mem [0:127];

	accel_spi_top uut (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_wr_data(host_wr_data),
		.host_rd_data(host_rd_data),
		.spi_ss(spi_ss),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso)
	);

	accel_slave_model u_model (
		.ss(spi_ss),
		.sck(spi_sck),
		.mosi(spi_mosi),
		.miso(spi_miso)
	);

	accel_checker u_chk (
		.clk(clk),
		.rst(rst),
		.spi_ss(spi_ss),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.error_count(error_count)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
		@(posedge clk);
		#5;
		host_wr = 1'b1;
		host_addr = a;
		host_wr_data = d;
		@(posedge clk);
		#5;
		host_wr = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] a, output logic [7:0] d);
		@(posedge clk);
		#5;
		host_addr = a;
		@(negedge clk);
		d = host_rd_data;
	endtask

	task automatic wait_status(input logic [7:0] mask, input logic [7:0] want,
		input string what);
		logic [7:0] st;
		int n;
		for (n = 0; n < 2000; n++) begin
			read_reg(accel_pkg::reg_status, st);
			if ((st & mask) == want) return;
		end
		$display("timeout after 2000 cycles waiting for %s", what);
		u_chk.report_totals();
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic randomize_memory();
		int i;
		for (i = 0; i < 128; i++) begin
			u_model.mem[i] = 8'($urandom);
		end
	endtask

	// sensor bytes come high first per axis, host registers put low below high
	task automatic verify_samples();
		logic [7:0] d;
		logic [3:0] a;
		int k;
		for (k = 0; k < 6; k++) begin
			if (k % 2 == 0) a = accel_pkg::reg_x_h + 4'(k);
			else a = accel_pkg::reg_x_l + 4'(k - 1);
			read_reg(a, d);
			u_chk.check_value($sformatf("sample register %0d", a), 16'(d),
				16'(exp_mem[accel_pkg::accel_data_base + 7'(k)]));
		end
	endtask

	task automatic run_measure(input logic use_cfg, input logic [6:0] caddr,
		input logic [7:0] cdata, input logic start_again);
		logic [7:0] ctrl;
		logic [7:0] st;
		int i;
		int k;
		for (i = 0; i < 128; i++) begin
			exp_mem[i] = u_model.mem[i];
		end
		if (use_cfg) begin
			write_reg(accel_pkg::reg_cfg_addr, {1'b0, caddr});
			write_reg(accel_pkg::reg_cfg_data, cdata);
			exp_mem[caddr] = cdata;
			u_chk.expect_frame(1'b0, caddr);
		end
		for (k = 0; k < 6; k++) begin
			u_chk.expect_frame(1'b1, accel_pkg::accel_data_base + 7'(k));
		end
		ctrl = '0;
		ctrl[accel_pkg::ctrl_start_bit] = 1'b1;
		ctrl[accel_pkg::ctrl_cfg_en_bit] = use_cfg;
		write_reg(accel_pkg::reg_ctrl, ctrl);
		// a new start clears valid and raises busy
		read_reg(accel_pkg::reg_status, st);
		u_chk.check_value("status after start", 16'(st), 16'(busy_mask));
		if (start_again) begin
			wait_status(busy_mask, busy_mask, "busy after start");
			write_reg(accel_pkg::reg_ctrl, ctrl);
		end
		wait_status(busy_mask, 8'h00, "measurement done");
		verify_samples();
		read_reg(accel_pkg::reg_status, st);
		u_chk.check_value("status", 16'(st), 16'(valid_mask));
		if (use_cfg) begin
			u_chk.check_value("model memory at config address", 16'(u_model.mem[caddr]),
				16'(cdata));
		end
	endtask

	initial begin
		logic [7:0] d;
		logic [6:0] caddr;
		logic [7:0] cdata;
		logic use_cfg;
		int i;
		int run;
		void'($urandom(33068));
		rst = 1'b1;
		host_wr = 1'b0;
		host_addr = '0;
		host_wr_data = '0;
		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;

		u_chk.check_value("spi_ss", 16'(spi_ss), 16'h1);
		u_chk.check_value("spi_sck", 16'(spi_sck), 16'h1);
		u_chk.check_value("spi_mosi", 16'(spi_mosi), 16'h0);
		for (i = 0; i < 10; i++) begin
			read_reg(4'(i), d);
			u_chk.check_value($sformatf("register %0d", i), 16'(d), 16'h0);
		end
		u_chk.finish_test("reset_state");

		randomize_memory();
		run_measure(1'b0, 7'd0, 8'd0, 1'b0);
		u_chk.finish_test("measure_without_config");

		randomize_memory();
		caddr = accel_pkg::accel_data_base + 7'($urandom % 6);
		cdata = 8'($urandom);
		run_measure(1'b1, caddr, cdata, 1'b0);
		u_chk.finish_test("config_write");

		randomize_memory();
		run_measure(1'b0, 7'd0, 8'd0, 1'b1);
		u_chk.finish_test("start_while_busy");

		for (run = 0; run < 20; run++) begin
			randomize_memory();
			use_cfg = 1'($urandom);
			caddr = 7'($urandom);
			// half the config writes land on a data register
			if (caddr[0]) caddr = accel_pkg::accel_data_base + 7'($urandom % 6);
			cdata = 8'($urandom);
			run_measure(use_cfg, caddr, cdata, 1'b0);
			u_chk.finish_test($sformatf("random_run_%0d", run));
		end

		u_chk.report_totals();
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: filelist.f
source/accel_pkg.sv
source/spi_accel_master.sv
source/accel_sequencer.sv
source/accel_regs.sv
source/accel_spi_top.sv
tb/accel_slave_model.sv
tb/accel_checker.sv
tb/accel_spi_tb.sv

// File: Makefile
TOP = accel_spi_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
